// File: design/alu.sv
`timescale 1ns/10ps

module alu (
    input  cpu_pkg::byte_t   a_in,
    input  cpu_pkg::byte_t   b_in,
    input  logic             carry_in,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::byte_t   result,
    output logic             carry_out,
    output logic             overflow
);
    import cpu_pkg::*;

    logic       subtract;
    logic       carry;
    byte_t      addend;
    logic [8:0] sum;       // Binary sum with carry out

    assign subtract = (op == ALU_OP_SBC) || (op == ALU_OP_CMP);
    assign carry    = (op == ALU_OP_CMP) | carry_in;  // CMP ignores C
    assign addend   = subtract ? ~b_in : b_in;        // A + ~B + C is A - B - borrow
    assign sum      = {1'b0, a_in} + {1'b0, addend} + {8'h00, carry};

    always_comb
    begin
        case (op)
            ALU_OP_ORA: result = a_in | b_in;
            ALU_OP_AND: result = a_in & b_in;
            ALU_OP_EOR: result = a_in ^ b_in;
            ALU_OP_ADC: result = sum[7:0];
            ALU_OP_LDA: result = b_in;             // Loads of A, X and Y
            ALU_OP_CMP: result = sum[7:0];         // Only for N and Z
            ALU_OP_SBC: result = sum[7:0];
            default:    result = 8'h00;
        endcase
    end

    assign carry_out = sum[8];
    assign overflow  = (a_in[7] ^ sum[7]) & (addend[7] ^ sum[7]);  // Sign change of both operands

endmodule

// File: design/bus_capture.sv
`timescale 1ns/10ps

module bus_capture (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 io_enable,
    input  cpu_pkg::byte_t       io_data_in,
    input  cpu_pkg::control_t    control,
    input  cpu_pkg::byte_t       data_out,
    output cpu_pkg::byte_t       captured,
    output cpu_pkg::byte_t       opcode,
    output cpu_pkg::decoded_op_t decoded
);
    import cpu_pkg::*;

    logic group_imm;  // Arithmetic group immediate, xxx_010_01
    logic group_zp;   // Arithmetic group zero page, xxx_001_01
    logic index_imm;  // LDY and LDX immediate
    logic index_zp;   // STY STX LDY LDX zero page

    // Bus byte of every enabled cycle
    always_ff @(posedge clock)
    begin
        if (io_enable)
            captured <= control.write_enable ? data_out : io_data_in;  // Written byte after a store
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            opcode <= RESET_OPCODE;
        else if (io_enable && control.sync)
            opcode <= io_data_in;
    end

    assign group_imm = (opcode ==? 8'b???01001) && (opcode != 8'h89);  // No STA immediate
    assign group_zp  = opcode ==? 8'b???00101;
    assign index_imm = opcode ==? 8'b101000?0;
    assign index_zp  = opcode ==? 8'b10?001?0;

    always_comb
    begin
        decoded.is_immediate  = group_imm | index_imm;
        decoded.is_zero_page  = group_zp | index_zp;
        decoded.is_jump       = opcode == 8'h4c;
        decoded.is_branch     = opcode ==? 8'b???10000;
        decoded.is_store      = (group_zp | index_zp) & (opcode[7:5] == 3'b100);
        decoded.is_load       = (group_imm | group_zp | index_imm | index_zp)
                                & (opcode[7:5] == 3'b101);
        decoded.is_arith      = (group_imm | group_zp) & (opcode[7:6] != 2'b10);
        decoded.is_transfer   = opcode inside {8'haa, 8'ha8, 8'h8a, 8'h98};
        decoded.is_count      = opcode inside {8'he8, 8'hc8, 8'hca, 8'h88};
        decoded.loads_a       = (decoded.is_load & opcode[0]) | (opcode inside {8'h8a, 8'h98});
        decoded.loads_x       = (decoded.is_load & (opcode[1:0] == 2'b10))
                                | (opcode inside {8'haa, 8'he8, 8'hca});
        decoded.loads_y       = (decoded.is_load & (opcode[1:0] == 2'b00))
                                | (opcode inside {8'ha8, 8'hc8, 8'h88});
        decoded.is_flag_op    = (opcode ==? 8'b???11000) && (opcode != 8'h98);  // 98 is TYA
        decoded.writes_nz     = decoded.is_load | decoded.is_arith
                                | decoded.is_transfer | decoded.is_count;
        decoded.alu_op        = alu_op_t'(opcode[7:5]);
        decoded.branch_select = flag_sel_t'(opcode[7:6]);

        // Source register of moves and counts, stores use opcode bits 1:0
        case (opcode)
            8'haa, 8'ha8:        decoded.reg_select = REG_A;
            8'h8a, 8'he8, 8'hca: decoded.reg_select = REG_X;
            8'h98, 8'hc8, 8'h88: decoded.reg_select = REG_Y;
            default:             decoded.reg_select = reg_sel_t'(opcode[1:0]);
        endcase
    end

endmodule

// File: design/bus_drive.sv
`timescale 1ns/10ps

module bus_drive (
    input  cpu_pkg::control_t control,
    input  cpu_pkg::addr_t    pc,
    input  cpu_pkg::byte_t    captured,
    input  cpu_pkg::byte_t    store_value,
    output cpu_pkg::addr_t    io_address,
    output cpu_pkg::byte_t    io_data_out,
    output logic              io_write_enable,
    output logic              io_sync
);
    import cpu_pkg::*;

    // Zero-page operand was captured in the operand cycle
    assign io_address = control.address_zero_page ? {ZERO_PAGE_HIGH, captured} : pc;

    assign io_data_out     = store_value;           // Only sampled with write enable
    assign io_write_enable = control.write_enable;
    assign io_sync         = control.sync;          // High on every opcode read

endmodule

// File: design/cpu_pkg.sv
package cpu_pkg;

    typedef logic [7:0]  byte_t;      // Data bus and register width
    typedef logic [15:0] addr_t;      // Bus address
    typedef logic [2:0]  alu_op_t;    // Opcode bits 7:5 of the arithmetic group
    typedef logic [1:0]  reg_sel_t;   // Register read by a store, move or count
    typedef logic [1:0]  flag_sel_t;  // Flag tested by a branch

    // One state per bus cycle of an instruction
    typedef enum logic [2:0] {
        fetch,         // Opcode read, previous instruction commits
        operand,       // Byte after the opcode
        address_high,  // High byte of a JMP target
        zero_page,     // Zero-page read or write
        branch_low,    // Add offset to PCL
        branch_high    // Fix PCH after a page crossing
    } cpu_state_e;

    typedef struct packed {
        logic      is_immediate;
        logic      is_zero_page;
        logic      is_jump;
        logic      is_branch;
        logic      is_store;
        logic      is_load;
        logic      is_arith;      // ORA AND EOR ADC CMP SBC
        logic      loads_a;
        logic      loads_x;
        logic      loads_y;
        logic      is_transfer;
        logic      is_count;      // INX INY DEX DEY
        logic      is_flag_op;
        logic      writes_nz;
        reg_sel_t  reg_select;
        alu_op_t   alu_op;
        flag_sel_t branch_select;
    } decoded_op_t;

    typedef struct packed {
        logic pc_increment;
        logic pc_vector;          // PC from the last two bytes read
        logic pc_branch_low;
        logic pc_branch_high;
        logic address_zero_page;  // Address is 00 and the captured byte
        logic write_enable;
        logic commit;             // Write back results of the previous instruction
        logic sync;
    } control_t;

    typedef struct packed {
        logic n;
        logic v;
        logic d;
        logic i;
        logic z;
        logic c;
    } status_t;

    localparam addr_t    RESET_VECTOR   = 16'hfffc;
    localparam byte_t    RESET_OPCODE   = 8'h4c;    // JMP absolute through the vector
    localparam byte_t    ZERO_PAGE_HIGH = 8'h00;

    localparam alu_op_t  ALU_OP_ORA = 3'b000;
    localparam alu_op_t  ALU_OP_AND = 3'b001;
    localparam alu_op_t  ALU_OP_EOR = 3'b010;
    localparam alu_op_t  ALU_OP_ADC = 3'b011;
    localparam alu_op_t  ALU_OP_LDA = 3'b101;
    localparam alu_op_t  ALU_OP_CMP = 3'b110;
    localparam alu_op_t  ALU_OP_SBC = 3'b111;

    // Same coding as opcode bits 1:0 of STY, STA and STX
    localparam reg_sel_t REG_Y = 2'b00;
    localparam reg_sel_t REG_A = 2'b01;
    localparam reg_sel_t REG_X = 2'b10;

endpackage

// File: design/cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
    input  logic              clock,
    input  logic              reset,
    input  logic              io_enable,
    input  cpu_pkg::byte_t    io_data_in,
    output cpu_pkg::addr_t    io_address,
    output cpu_pkg::byte_t    io_data_out,
    output logic              io_write_enable,
    output logic              io_sync,
    output cpu_pkg::byte_t    io_debug_opcode,
    output cpu_pkg::byte_t    io_debug_a,
    output cpu_pkg::byte_t    io_debug_x,
    output cpu_pkg::byte_t    io_debug_y,
    output cpu_pkg::addr_t    io_debug_pc,
    output cpu_pkg::status_t  io_debug_status
);
    import cpu_pkg::*;

    control_t    control;
    decoded_op_t decoded;
    byte_t       captured;
    byte_t       store_value;
    logic        branch_taken;
    logic        branch_carry;

    bus_capture capture0 (
        .clock      (clock),
        .reset      (reset),
        .io_enable  (io_enable),
        .io_data_in (io_data_in),
        .control    (control),
        .data_out   (io_data_out),
        .captured   (captured),
        .opcode     (io_debug_opcode),
        .decoded    (decoded)
    );

    sequencer sequencer0 (
        .clock        (clock),
        .reset        (reset),
        .io_enable    (io_enable),
        .decoded      (decoded),
        .branch_taken (branch_taken),
        .branch_carry (branch_carry),
        .control      (control)
    );

    register_file registers0 (
        .clock        (clock),
        .reset        (reset),
        .io_enable    (io_enable),
        .control      (control),
        .decoded      (decoded),
        .opcode       (io_debug_opcode),
        .captured     (captured),
        .bus_high     (io_data_in),       // High byte of a vector, same cycle
        .pc           (io_debug_pc),
        .store_value  (store_value),
        .a            (io_debug_a),
        .x            (io_debug_x),
        .y            (io_debug_y),
        .status       (io_debug_status),
        .branch_taken (branch_taken),
        .branch_carry (branch_carry)
    );

    bus_drive drive0 (
        .control         (control),
        .pc              (io_debug_pc),
        .captured        (captured),
        .store_value     (store_value),
        .io_address      (io_address),
        .io_data_out     (io_data_out),
        .io_write_enable (io_write_enable),
        .io_sync         (io_sync)
    );

endmodule

// File: design/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 io_enable,
    input  cpu_pkg::control_t    control,
    input  cpu_pkg::decoded_op_t decoded,
    input  cpu_pkg::byte_t       opcode,
    input  cpu_pkg::byte_t       captured,
    input  cpu_pkg::byte_t       bus_high,
    output cpu_pkg::addr_t       pc,
    output cpu_pkg::byte_t       store_value,
    output cpu_pkg::byte_t       a,
    output cpu_pkg::byte_t       x,
    output cpu_pkg::byte_t       y,
    output cpu_pkg::status_t     status,
    output logic                 branch_taken,
    output logic                 branch_carry
);
    import cpu_pkg::*;

    byte_t      alu_result;
    logic       alu_carry;
    logic       alu_overflow;
    byte_t      source;         // Register for a store, move or count
    byte_t      count_result;
    logic       count_down;
    byte_t      data_bus;       // Value written back at commit
    logic       write_a;
    logic       uses_carry;     // ADC SBC CMP
    logic       uses_overflow;  // ADC SBC
    logic       flag_value;
    logic [3:0] branch_flags;
    logic [9:0] branch_sum;     // PCL plus signed offset, two carry bits
    logic [1:0] branch_fix;     // Page step saved for branch_high

    alu alu0 (
        .a_in      (a),
        .b_in      (captured),
        .carry_in  (status.c),
        .op        (decoded.alu_op),
        .result    (alu_result),
        .carry_out (alu_carry),
        .overflow  (alu_overflow)
    );

    always_comb
    begin
        case (decoded.reg_select)
            REG_A:   source = a;
            REG_X:   source = x;
            default: source = y;
        endcase
    end

    assign store_value  = source;
    assign count_down   = opcode[1] | ~opcode[6];  // DEX is CA, DEY is 88
    assign count_result = count_down ? source - 8'd1 : source + 8'd1;
    assign data_bus     = decoded.is_count ? count_result :
                          decoded.is_transfer ? source : alu_result;

    assign write_a       = decoded.loads_a | (decoded.is_arith && decoded.alu_op != ALU_OP_CMP);
    assign uses_carry    = decoded.is_arith
                           & ((decoded.alu_op[1] & decoded.alu_op[0])
                              | (decoded.alu_op == ALU_OP_CMP));
    assign uses_overflow = decoded.is_arith & decoded.alu_op[1] & decoded.alu_op[0];
    assign flag_value    = opcode[5] & (opcode[7:6] != 2'b10);  // CLV has bit 5 set but clears

    // BPL/BMI, BVC/BVS, BCC/BCS, BNE/BEQ
    assign branch_flags = {status.z, status.c, status.v, status.n};
    assign branch_taken = branch_flags[decoded.branch_select] == opcode[5];
    assign branch_sum   = {2'b00, pc[7:0]} + {{2{captured[7]}}, captured};
    assign branch_carry = branch_sum[9:8] != 2'b00;

    always_ff @(posedge clock)
    begin
        if (io_enable && control.pc_branch_low)
            branch_fix <= branch_sum[9:8];  // 01 next page, 11 previous page
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            a      <= '0;
            x      <= '0;
            y      <= '0;
            status <= '{i: 1'b1, default: 1'b0};
            pc     <= RESET_VECTOR;
        end
        else if (io_enable)
        begin
            if (control.commit)
            begin
                if (write_a) a <= data_bus;
                if (decoded.loads_x) x <= data_bus;
                if (decoded.loads_y) y <= data_bus;
                if (decoded.writes_nz)
                begin
                    status.n <= data_bus[7];
                    status.z <= data_bus == 8'h00;
                end
                if (uses_carry) status.c <= alu_carry;
                if (uses_overflow) status.v <= alu_overflow;
                if (decoded.is_flag_op)
                begin
                    case (opcode[7:6])
                        2'b00:   status.c <= flag_value;
                        2'b01:   status.i <= flag_value;
                        2'b10:   status.v <= flag_value;
                        default: status.d <= flag_value;
                    endcase
                end
            end

            if (control.pc_vector)
                pc <= {bus_high, captured};
            else if (control.pc_branch_low)
                pc[7:0] <= branch_sum[7:0];
            else if (control.pc_branch_high)
                pc[15:8] <= pc[15:8] + {{7{branch_fix[1]}}, branch_fix[0]};
            else if (control.pc_increment)
                pc <= pc + 16'd1;
        end
    end

endmodule

// File: design/sequencer.sv
`timescale 1ns/10ps

module sequencer (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 io_enable,
    input  cpu_pkg::decoded_op_t decoded,
    input  logic                 branch_taken,
    input  logic                 branch_carry,
    output cpu_pkg::control_t    control
);
    import cpu_pkg::*;

    cpu_state_e state;
    cpu_state_e next_state;
    logic       has_operand;  // Two-byte or three-byte instruction

    assign has_operand = decoded.is_immediate | decoded.is_zero_page
                         | decoded.is_jump | decoded.is_branch;

    always_comb
    begin
        control    = '0;
        next_state = fetch;
        case (state)
            fetch:
            begin
                control.sync         = 1'b1;
                control.commit       = 1'b1;  // Results of the last instruction
                control.pc_increment = 1'b1;
                next_state           = operand;
            end
            operand:
            begin
                // Implied and unknown opcodes leave PC on the next opcode
                control.pc_increment = has_operand;
                if (decoded.is_zero_page)
                    next_state = zero_page;
                else if (decoded.is_jump)
                    next_state = address_high;
                else if (decoded.is_branch && branch_taken)
                    next_state = branch_low;
            end
            address_high:
            begin
                control.pc_vector = 1'b1;  // Low byte captured, high byte on the bus
            end
            zero_page:
            begin
                control.address_zero_page = 1'b1;
                control.write_enable      = decoded.is_store;
            end
            branch_low:
            begin
                control.pc_branch_low = 1'b1;
                if (branch_carry)
                    next_state = branch_high;  // Target in the next or previous page
            end
            branch_high:
            begin
                control.pc_branch_high = 1'b1;
            end
            default:
            begin
                next_state = fetch;
            end
        endcase
    end

    // Reset enters the JMP of the vector at its operand cycle
    always_ff @(posedge clock)
    begin
        if (reset)
            state <= operand;
        else if (io_enable)
            state <= next_state;
    end

endmodule

// File: project.f
+incdir+include
design/cpu_pkg.sv
design/alu.sv
design/bus_capture.sv
design/sequencer.sv
design/register_file.sv
design/bus_drive.sv
design/cpu_top.sv
test/cpu_tb.sv

// File: include/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// Kept opcodes, the generator picks one byte at random
localparam logic [45*8-1:0] OPCODE_LIST = {
    8'ha9, 8'ha2, 8'ha0, 8'ha5, 8'ha6, 8'ha4, 8'h85, 8'h86, 8'h84,  // Loads and stores
    8'h09, 8'h29, 8'h49, 8'h69, 8'hc9, 8'he9,                       // Immediate arithmetic
    8'h05, 8'h25, 8'h45, 8'h65, 8'hc5, 8'he5,                       // Zero-page arithmetic
    8'haa, 8'ha8, 8'h8a, 8'h98, 8'he8, 8'hc8, 8'hca, 8'h88,         // Moves and counts
    8'h18, 8'h38, 8'h58, 8'h78, 8'hb8, 8'hd8, 8'hf8, 8'h4c,         // Flags and JMP
    8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hb0, 8'hd0, 8'hf0          // Branches
};

byte_t   ref_mem [0:65535];     // Memory image as the ISA sees it
addr_t   slot_addr [0:PROG_LENGTH];
byte_t   exp_a;
byte_t   exp_x;
byte_t   exp_y;
status_t exp_status;
addr_t   exp_pc;
int      exp_cycles;            // Bus cycles of the instruction just executed
int      taken_count;
int      cross_count;
addr_t   write_addr_q [$];      // Stores still to appear on the bus
byte_t   write_data_q [$];

function automatic int instr_length(byte_t op);
    case (op)
        8'h4c:   return 3;
        8'haa, 8'ha8, 8'h8a, 8'h98, 8'he8, 8'hc8, 8'hca, 8'h88,
        8'h18, 8'h38, 8'h58, 8'h78, 8'hb8, 8'hd8, 8'hf8:
                 return 1;   // Implied
        default: return 2;
    endcase
endfunction

// N and Z follow the value, which is passed through
function automatic byte_t update_nz(byte_t value);
    exp_status.n = value[7];
    exp_status.z = (value == 8'h00);
    return value;
endfunction

task automatic store_byte(byte_t zp, byte_t value);
    ref_mem[{8'h00, zp}] = value;
    write_addr_q.push_back({8'h00, zp});
    write_data_q.push_back(value);
endtask

task automatic add_to_a(byte_t value);
    int    sum;
    byte_t result;
    sum    = int'(exp_a) + int'(value) + int'(exp_status.c);
    result = byte_t'(sum);
    exp_status.c = sum > 255;
    exp_status.v = (exp_a[7] == value[7]) && (result[7] != exp_a[7]);  // Same signs, new sign
    exp_a = update_nz(result);
endtask

// SBC with borrow = not C, CMP with no borrow and A kept
task automatic subtract_from_a(byte_t value, logic borrow, logic write_a);
    int    diff;
    byte_t result;
    diff   = int'(exp_a) - int'(value) - int'(borrow);
    result = byte_t'(diff);
    exp_status.c = diff >= 0;
    void'(update_nz(result));
    if (write_a)
    begin
        exp_status.v = (exp_a[7] != value[7]) && (result[7] != exp_a[7]);
        exp_a = result;
    end
endtask

task automatic generate_program;
    byte_t slot_op [0:PROG_LENGTH];
    addr_t pc;
    addr_t next;
    int    j;
    int    offset;
    int    diff;
    for (int i = 0; i < 65536; i++)
        ref_mem[i] = byte_t'(i ^ (i >> 8) ^ 8'h5a);  // Fill tied to both address bytes
    for (int i = 0; i < DATA_SIZE; i++)
        ref_mem[DATA_BASE + i] = byte_t'($urandom);
    pc = PROG_START;
    for (int i = 0; i < PROG_LENGTH; i++)
    begin
        slot_op[i]   = OPCODE_LIST[8 * $urandom_range(44, 0) +: 8];
        slot_addr[i] = pc;
        pc           = pc + addr_t'(instr_length(slot_op[i]));
    end
    slot_op[PROG_LENGTH]   = 8'h4c;  // Closing JMP back to the start
    slot_addr[PROG_LENGTH] = pc;
    for (int i = 0; i <= PROG_LENGTH; i++)
    begin
        pc          = slot_addr[i];
        ref_mem[pc] = slot_op[i];
        if (slot_op[i] == 8'h4c)
        begin
            // Forward targets only, so loops go through the closing JMP
            next = (i == PROG_LENGTH) ? PROG_START
                                      : slot_addr[$urandom_range(PROG_LENGTH, i + 1)];
            ref_mem[pc + 16'd1] = next[7:0];
            ref_mem[pc + 16'd2] = next[15:8];
        end
        else if (slot_op[i][4:0] == 5'b10000)
        begin
            offset = 0;  // Falls back to the next instruction
            for (int t = 0; t < 8 && offset == 0; t++)
            begin
                j = i + int'($urandom_range(40, 0)) - 12;
                if (j >= 0 && j <= PROG_LENGTH && j != i)
                begin
                    diff = int'(slot_addr[j]) - int'(pc) - 2;
                    if (diff >= -128 && diff <= 127)
                        offset = diff;
                end
            end
            ref_mem[pc + 16'd1] = byte_t'(offset);
        end
        else if (instr_length(slot_op[i]) == 2)
            ref_mem[pc + 16'd1] = (slot_op[i][3:2] == 2'b01) ?
                                  DATA_BASE + byte_t'($urandom_range(DATA_SIZE - 1, 0)) :
                                  byte_t'($urandom);
    end
    ref_mem[16'hfffc] = PROG_START[7:0];   // Reset vector
    ref_mem[16'hfffd] = PROG_START[15:8];
endtask

task automatic execute_instruction;
    byte_t op;
    byte_t b1;
    byte_t value;
    addr_t next;
    addr_t target;
    logic  take;
    op    = ref_mem[exp_pc];
    b1    = ref_mem[exp_pc + 16'd1];
    value = (op[3:2] == 2'b01) ? ref_mem[{8'h00, b1}] : b1;  // Zero-page forms are xxxx01xx
    next  = exp_pc + addr_t'(instr_length(op));
    take  = 1'b0;
    exp_cycles = (op == 8'h4c || op[3:2] == 2'b01) ? 3 : 2;
    case (op)
        8'ha9, 8'ha5: exp_a = update_nz(value);
        8'ha2, 8'ha6: exp_x = update_nz(value);
        8'ha0, 8'ha4: exp_y = update_nz(value);
        8'h85:        store_byte(b1, exp_a);
        8'h86:        store_byte(b1, exp_x);
        8'h84:        store_byte(b1, exp_y);
        8'h09, 8'h05: exp_a = update_nz(exp_a | value);
        8'h29, 8'h25: exp_a = update_nz(exp_a & value);
        8'h49, 8'h45: exp_a = update_nz(exp_a ^ value);
        8'h69, 8'h65: add_to_a(value);
        8'he9, 8'he5: subtract_from_a(value, !exp_status.c, 1'b1);
        8'hc9, 8'hc5: subtract_from_a(value, 1'b0, 1'b0);
        8'haa:        exp_x = update_nz(exp_a);
        8'ha8:        exp_y = update_nz(exp_a);
        8'h8a:        exp_a = update_nz(exp_x);
        8'h98:        exp_a = update_nz(exp_y);
        8'he8:        exp_x = update_nz(exp_x + 8'd1);
        8'hc8:        exp_y = update_nz(exp_y + 8'd1);
        8'hca:        exp_x = update_nz(exp_x - 8'd1);
        8'h88:        exp_y = update_nz(exp_y - 8'd1);
        8'h18:        exp_status.c = 1'b0;
        8'h38:        exp_status.c = 1'b1;
        8'h58:        exp_status.i = 1'b0;
        8'h78:        exp_status.i = 1'b1;
        8'hb8:        exp_status.v = 1'b0;
        8'hd8:        exp_status.d = 1'b0;
        8'hf8:        exp_status.d = 1'b1;
        8'h4c:        next = {ref_mem[exp_pc + 16'd2], b1};
        8'h10:        take = !exp_status.n;  // BPL
        8'h30:        take = exp_status.n;
        8'h50:        take = !exp_status.v;  // BVC
        8'h70:        take = exp_status.v;
        8'h90:        take = !exp_status.c;  // BCC
        8'hb0:        take = exp_status.c;
        8'hd0:        take = !exp_status.z;  // BNE
        8'hf0:        take = exp_status.z;
        default:      ;
    endcase
    if (take)
    begin
        target     = next + {{8{b1[7]}}, b1};
        exp_cycles = (target[15:8] == next[15:8]) ? 3 : 4;  // Extra cycle on a page crossing
        taken_count++;
        cross_count += (exp_cycles == 4);
        next = target;
    end
    exp_pc = next;
endtask

`endif

// File: test/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int    SEED          = 84;
    localparam int    PROG_LENGTH   = 160;        // Instructions in the generated program
    localparam int    INSTR_COUNT   = 600;        // Instructions executed in the run
    localparam int    STALL_PERCENT = 25;
    localparam addr_t PROG_START    = 16'h02c0;   // Program starts in page 02 and runs into 03
    localparam byte_t DATA_BASE     = 8'h10;
    localparam int    DATA_SIZE     = 48;
    localparam int    TIME_LIMIT    = (INSTR_COUNT * 4 * 4 + 200) * 10;  // In ns
    localparam int    T_RESET       = 0;
    localparam int    T_REGS        = 1;
    localparam int    T_FLAGS       = 2;
    localparam int    T_STORES      = 3;
    localparam int    T_FLOW        = 4;
    localparam int    T_STALL       = 5;

    typedef struct packed {
        addr_t address;
        byte_t data;
        logic  write_enable;
        logic  sync;
    } bus_out_t;

    logic    clock;
    logic    reset;
    logic    io_enable;
    byte_t   io_data_in;
    addr_t   io_address;
    byte_t   io_data_out;
    logic    io_write_enable;
    logic    io_sync;
    byte_t   io_debug_opcode;
    byte_t   io_debug_a;
    byte_t   io_debug_x;
    byte_t   io_debug_y;
    addr_t   io_debug_pc;
    status_t io_debug_status;

    byte_t mem [0:65535];   // Memory seen by the DUT
    int    checks [0:5];
    int    errors [0:5];
    string test_name [0:5];
    int    executed;

    `include "cpu_ref_model.svh"

    cpu_top dut0 (
        .clock           (clock),
        .reset           (reset),
        .io_enable       (io_enable),
        .io_data_in      (io_data_in),
        .io_address      (io_address),
        .io_data_out     (io_data_out),
        .io_write_enable (io_write_enable),
        .io_sync         (io_sync),
        .io_debug_opcode (io_debug_opcode),
        .io_debug_a      (io_debug_a),
        .io_debug_x      (io_debug_x),
        .io_debug_y      (io_debug_y),
        .io_debug_pc     (io_debug_pc),
        .io_debug_status (io_debug_status)
    );

    assign io_data_in = mem[io_address];  // Read data in the same cycle

    always #5 clock = ~clock;

    always @(posedge clock)
    begin
        if (io_enable && io_write_enable)
            mem[io_address] <= io_data_out;
    end

    task automatic check_value(input int test, input string what, input logic [31:0] got,
                               input logic [31:0] want);
        checks[test]++;
        assert (got === want)
        else
        begin
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, want);
            errors[test]++;
        end
    endtask

    task automatic report_test(input int test);
        $display("Test %-8s finished: %0d checks, %0d errors",
                 test_name[test], checks[test], errors[test]);
    endtask

    initial
    begin
        #(TIME_LIMIT);
        $display("Run timed out after %0d ns with %0d of %0d instructions executed",
                 TIME_LIMIT, executed, INSTR_COUNT);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        bus_out_t now;
        bus_out_t prev;
        logic     has_prev;
        logic     last_enable;
        logic     pending;      // Registers due at the next sample after a fetch
        logic     synced;
        int       cycles;
        int       total_checks;
        int       total_errors;
        void'($urandom(SEED));
        clock     = 1'b0;
        reset     = 1'b1;
        io_enable = 1'b0;
        test_name = '{"reset", "regs", "flags", "stores", "flow", "stall"};
        for (int t = 0; t < 6; t++)
        begin
            checks[t] = 0;
            errors[t] = 0;
        end
        generate_program();
        for (int i = 0; i < 65536; i++)
            mem[i] = ref_mem[i];
        exp_a      = 8'h00;
        exp_x      = 8'h00;
        exp_y      = 8'h00;
        exp_status = '0;
        exp_status.i = 1'b1;     // Interrupts masked out of reset
        exp_pc     = {ref_mem[16'hfffd], ref_mem[16'hfffc]};
        exp_cycles = 2;          // Two vector reads before the first fetch
        has_prev   = 1'b0;
        pending    = 1'b0;
        synced     = 1'b0;
        cycles     = 0;
        executed   = 0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // One pass per falling edge where outputs have settled since the rising edge
        while (executed < INSTR_COUNT)
        begin
            now = {io_address, io_data_out, io_write_enable, io_sync};
            if (has_prev && !last_enable)
                check_value(T_STALL, "bus outputs over a stall", now, prev);
            if (pending)
            begin
                check_value(T_FLOW, "opcode", io_debug_opcode, ref_mem[exp_pc]);
                check_value(T_REGS, "A", io_debug_a, exp_a);
                check_value(T_REGS, "X", io_debug_x, exp_x);
                check_value(T_REGS, "Y", io_debug_y, exp_y);
                check_value(T_FLAGS, "status", io_debug_status, exp_status);
                execute_instruction();
                executed++;
                pending = 1'b0;
            end
            io_enable = ($urandom_range(99, 0) >= STALL_PERCENT);
            if (!synced)
            begin
                checks[T_RESET]++;
                assert (!io_write_enable)
                else
                begin
                    $display("Write enable was raised before the first fetch at %0t", $time);
                    errors[T_RESET]++;
                end
            end
            if (io_enable && io_sync)
            begin
                check_value(T_FLOW, "fetch address", io_address, exp_pc);
                check_value(T_FLOW, "debug PC", io_debug_pc, exp_pc);
                check_value(T_FLOW, "cycles of the last instruction", cycles, exp_cycles);
                checks[T_STORES]++;
                assert (write_addr_q.size() == 0)
                else
                begin
                    $display("A store was missing before the fetch at %0t", $time);
                    errors[T_STORES]++;
                    write_addr_q.delete();
                    write_data_q.delete();
                end
                if (!synced)
                begin
                    check_value(T_RESET, "first fetch address", io_address,
                                {ref_mem[16'hfffd], ref_mem[16'hfffc]});
                    report_test(T_RESET);
                    synced = 1'b1;
                end
                cycles  = 0;
                pending = 1'b1;
            end
            if (io_enable && io_write_enable)
            begin
                checks[T_STORES]++;
                assert (write_addr_q.size() > 0)
                else
                begin
                    $display("Unexpected write to address %h at %0t", io_address, $time);
                    errors[T_STORES]++;
                end
                if (write_addr_q.size() > 0)
                begin
                    check_value(T_STORES, "store address", io_address, write_addr_q.pop_front());
                    check_value(T_STORES, "store data", io_data_out, write_data_q.pop_front());
                end
            end
            if (io_enable)
                cycles++;
            prev        = now;
            last_enable = io_enable;
            has_prev    = 1'b1;
            @(negedge clock);
        end

        total_checks = checks[T_RESET];
        total_errors = errors[T_RESET];
        for (int t = 1; t < 6; t++)
        begin
            report_test(t);
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("Checks %0d, errors %0d, branches taken %0d, page crossings %0d",
                 total_checks, total_errors, taken_count, cross_count);
        if (total_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule
